//--- source/ahb_mem_pkg.sv
`default_nettype none

package ahb_mem_pkg;

    // AHB-Lite transfer type.
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    // AHB-Lite burst type, only the codes this slave tracks.
    typedef enum logic [2:0] {
        SINGLE = 3'b000,
        INCR   = 3'b001,
        WRAP4  = 3'b010,
        INCR4  = 3'b011
    } hburst_e;

    localparam int unsigned DATA_W      = 32;
    localparam int unsigned MEM_WORDS   = 1024;
    localparam int unsigned WORD_ADDR_W = 10;      // Word index is haddr[11:2].

    localparam int unsigned READ_WAIT   = 2;       // hready low cycles per read.
    localparam int unsigned WRITE_WAIT  = 1;       // hready low cycles per write.
    localparam int unsigned WAIT_W      = 2;       // Wide enough for the larger wait.

endpackage

`default_nettype wire

//--- source/ahb_transfer_handler.sv
`default_nettype none
`timescale 1ns/1ps

module ahb_transfer_handler import ahb_mem_pkg::*; (
    input  wire logic                   mem_intf,
    input  wire logic                   rst_n,
    input  wire logic [31:0]            haddr,
    input  wire logic                   hwrite,
    input  wire htrans_e                htrans,
    input  wire hburst_e                hburst,
    input  wire logic                   hready,
    output logic                        acc_start,
    output logic                        acc_write,
    output logic [WORD_ADDR_W-1:0]      acc_index
);

    logic                   accept;
    logic [WORD_ADDR_W-1:0] addr_index;
    logic [WORD_ADDR_W-1:0] next_index;
    hburst_e                burst_q;
    logic [1:0]             beat_cnt;
    logic                   burst_open;

    // Address phase is taken only on an edge with hready high.
    assign accept     = hready && (htrans == NONSEQ || htrans == SEQ);
    assign addr_index = haddr[WORD_ADDR_W+1:2];    // Upper bits alias, byte bits dropped.

    // Next beat address, derived from the beat just issued.
    always_comb begin
        next_index = addr_index;
        if (burst_open) begin
            case (burst_q)
                INCR,
                INCR4: begin
                    next_index = acc_index + 1'b1;
                end
                WRAP4: begin
                    // Wrap inside the aligned four word block.
                    next_index = {acc_index[WORD_ADDR_W-1:2], acc_index[1:0] + 2'd1};
                end
                default: begin
                    next_index = addr_index;
                end
            endcase
        end
    end

    always_ff @(posedge mem_intf) begin
        if (!rst_n) begin
            acc_start  <= 1'b0;
            acc_write  <= 1'b0;
            burst_q    <= SINGLE;
            beat_cnt   <= 2'd0;
            burst_open <= 1'b0;
        end else begin
            acc_start <= accept;                   // One cycle, start of the data phase.
            if (accept) begin
                acc_write <= hwrite;
                if (htrans == NONSEQ) begin
                    burst_q    <= hburst;
                    beat_cnt   <= 2'd1;
                    burst_open <= (hburst != SINGLE);
                end else if (burst_q == INCR4 || burst_q == WRAP4) begin
                    beat_cnt <= beat_cnt + 2'd1;
                    if (beat_cnt == 2'd3) begin
                        burst_open <= 1'b0;        // Fourth beat closes the burst.
                    end
                end
            end
        end
    end

    // BUSY and IDLE leave the index alone, so a BUSY mid-burst holds it.
    always_ff @(posedge mem_intf) begin
        if (accept) begin
            acc_index <= (htrans == NONSEQ) ? addr_index : next_index;
        end
    end

endmodule

`default_nettype wire

//--- source/mem_wait_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module mem_wait_ctrl import ahb_mem_pkg::*; (
    input  wire logic mem_intf,
    input  wire logic rst_n,
    input  wire logic acc_start,
    input  wire logic acc_write,
    output logic      hready,
    output logic      acc_last
);

    logic [WAIT_W-1:0] wait_cnt;
    logic [WAIT_W-1:0] wait_load;
    logic              phase_open;

    assign wait_load = acc_write ? WAIT_W'(WRITE_WAIT) : WAIT_W'(READ_WAIT);

    // First data phase cycle is already a wait cycle when the count is nonzero.
    assign hready   = (wait_cnt == '0) && !(acc_start && (wait_load != '0));
    assign acc_last = hready && (acc_start || phase_open);

    always_ff @(posedge mem_intf) begin
        if (!rst_n) begin
            wait_cnt   <= '0;
            phase_open <= 1'b0;
        end else if (acc_start) begin
            // The acc_start cycle counts as the first wait.
            wait_cnt   <= (wait_load == '0) ? '0 : wait_load - 1'b1;
            phase_open <= (wait_load != '0);
        end else begin
            if (wait_cnt != '0) begin
                wait_cnt <= wait_cnt - 1'b1;
            end
            if (acc_last) begin
                phase_open <= 1'b0;                // Phase ends with hready high.
            end
        end
    end

endmodule

`default_nettype wire

//--- source/mem_word_array.sv
`default_nettype none
`timescale 1ns/1ps

module mem_word_array import ahb_mem_pkg::*; (
    input  wire logic                   mem_intf,
    input  wire logic                   rst_n,
    input  wire logic                   acc_start,
    input  wire logic                   acc_write,
    input  wire logic [WORD_ADDR_W-1:0] acc_index,
    input  wire logic                   acc_last,
    input  wire logic [DATA_W-1:0]      hwdata,
    output logic [DATA_W-1:0]           rd_data
);

    logic [DATA_W-1:0] mem [MEM_WORDS];
    logic [DATA_W-1:0] rd_word;

    // Write lands on the edge that closes the write data phase.
    always_ff @(posedge mem_intf) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (acc_last && acc_write) begin
            mem[acc_index] <= hwdata;
        end
    end

    always_ff @(posedge mem_intf) begin
        if (acc_start && !acc_write) begin
            rd_word <= mem[acc_index];             // Held through the wait cycles.
        end
    end

    // Bus sees the word only in the completing cycle of a read.
    assign rd_data = (acc_last && !acc_write) ? rd_word : '0;

endmodule

`default_nettype wire

//--- source/ahb_mem_top.sv
`default_nettype none
`timescale 1ns/1ps

module ahb_mem_top import ahb_mem_pkg::*; (
    input  wire logic              mem_intf,
    input  wire logic              rst_n,
    input  wire logic [31:0]       haddr,
    input  wire logic              hwrite,
    input  wire htrans_e           htrans,
    input  wire hburst_e           hburst,
    input  wire logic [DATA_W-1:0] hwdata,
    output logic [DATA_W-1:0]      hrdata,
    output logic                   hready
);

    logic                   acc_start;
    logic                   acc_write;
    logic [WORD_ADDR_W-1:0] acc_index;
    logic                   acc_last;

    ahb_transfer_handler u_handler (
        .mem_intf  (mem_intf),
        .rst_n     (rst_n),
        .haddr     (haddr),
        .hwrite    (hwrite),
        .htrans    (htrans),
        .hburst    (hburst),
        .hready    (hready),
        .acc_start (acc_start),
        .acc_write (acc_write),
        .acc_index (acc_index)
    );

    // Wait cycles and end of phase.
    mem_wait_ctrl u_wait (
        .mem_intf  (mem_intf),
        .rst_n     (rst_n),
        .acc_start (acc_start),
        .acc_write (acc_write),
        .hready    (hready),
        .acc_last  (acc_last)
    );

    mem_word_array u_array (
        .mem_intf  (mem_intf),
        .rst_n     (rst_n),
        .acc_start (acc_start),
        .acc_write (acc_write),
        .acc_index (acc_index),
        .acc_last  (acc_last),
        .hwdata    (hwdata),
        .rd_data   (hrdata)                        // Zero outside a completing read.
    );

endmodule

`default_nettype wire

//--- testbench/ahb_mem_assert.sv
`default_nettype none
`timescale 1ns/1ps

module ahb_mem_assert import ahb_mem_pkg::*; (
    input  wire logic              mem_intf,
    input  wire logic              rst_n,
    input  wire htrans_e           htrans,
    input  wire logic              hwrite,
    input  wire logic              hready,
    input  wire logic [DATA_W-1:0] hrdata
);

    logic       read_open;                         // A read data phase is running.
    logic [3:0] low_cnt;

    always_ff @(posedge mem_intf) begin
        if (!rst_n) begin
            read_open <= 1'b0;
            low_cnt   <= '0;
        end else if (hready) begin
            read_open <= !hwrite && (htrans == NONSEQ || htrans == SEQ);
            low_cnt   <= '0;
        end else begin
            low_cnt <= low_cnt + 4'd1;
        end
    end

    ready_after_reset: assert property (@(posedge mem_intf) $rose(rst_n) |-> hready)
        else $error("hready low in the first cycle after reset");

    read_wait_count: assert property (@(posedge mem_intf) disable iff (!rst_n)
        (read_open && hready) |-> (low_cnt == 4'(READ_WAIT)))
        else $error("read data phase has the wrong number of wait cycles");

    rdata_idle_zero: assert property (@(posedge mem_intf) disable iff (!rst_n)
        !(read_open && hready) |-> (hrdata == '0))
        else $error("hrdata nonzero outside a completing read");

endmodule

bind ahb_mem_top ahb_mem_assert u_assert (
    .mem_intf (mem_intf),
    .rst_n    (rst_n),
    .htrans   (htrans),
    .hwrite   (hwrite),
    .hready   (hready),
    .hrdata   (hrdata)
);

`default_nettype wire

//--- testbench/ahb_mem_tb.sv
`default_nettype none
`timescale 1ns/1ps

module ahb_mem_tb import ahb_mem_pkg::*; ();

    localparam int unsigned TIMEOUT_CYCLES = 16;

    typedef struct packed {
        hburst_e          burst;
        logic             write;
        logic [31:0]      addr;
        logic             busy;                    // BUSY cycle before the third beat.
        int unsigned      exp_wait;                // hready low cycles per beat.
        logic [3:0][31:0] data;
    } entry_t;

    typedef struct packed {
        htrans_e     trans;
        hburst_e     burst;
        logic        write;
        logic [31:0] addr;
        logic [31:0] data;
        int unsigned exp_wait;
    } phase_t;

    logic        mem_intf;
    logic        rst_n;
    logic [31:0] haddr;
    logic        hwrite;
    htrans_e     htrans;
    hburst_e     hburst;
    logic [31:0] hwdata;
    logic [31:0] hrdata;
    logic        hready;

    integer      seed;
    entry_t      xfer_table[$];
    logic [31:0] ref_mem[int unsigned];
    phase_t      idle_ph;
    phase_t      addr_ph;                          // Transfer in its address phase.
    phase_t      data_ph;                          // Transfer in its data phase.

    ahb_mem_top u_dut (
        .mem_intf (mem_intf),
        .rst_n    (rst_n),
        .haddr    (haddr),
        .hwrite   (hwrite),
        .htrans   (htrans),
        .hburst   (hburst),
        .hwdata   (hwdata),
        .hrdata   (hrdata),
        .hready   (hready)
    );

    initial begin
        mem_intf = 1'b0;
    end

    always #20 mem_intf = ~mem_intf;

    function automatic int unsigned word_index(input logic [31:0] addr);
        return {22'd0, addr[11:2]};
    endfunction

    // Beat address by the AHB burst rules.
    function automatic logic [31:0] beat_addr(input hburst_e burst, input logic [31:0] start,
                                              input int beat);
        logic [31:0] linear;
        linear = start + 32'(4 * beat);
        if (burst == WRAP4) begin
            return {start[31:4], linear[3:2], 2'b00};
        end
        return {linear[31:2], 2'b00};
    endfunction

    function automatic logic is_access(input phase_t ph);
        return ph.trans == NONSEQ || ph.trans == SEQ;
    endfunction

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        assert (got === exp) else begin
            $display("** Error at %0d ns: %s expected 0x%08h, got 0x%08h",
                     $time, name, exp, got);
            $display("STATUS: FAIL");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Returns at the edge that ends the current data phase.
    task automatic await_ready(output int unsigned lows, output logic [31:0] rdata);
        lows = 0;
        @(negedge mem_intf);
        while (hready !== 1'b1) begin
            lows++;
            if (lows > TIMEOUT_CYCLES) begin
                $display("hready stayed low for more than %0d cycles at %0d ns",
                         TIMEOUT_CYCLES, $time);
                $display("STATUS: FAIL");
                $fatal(1, "Timeout waiting for hready");
            end
            @(negedge mem_intf);
        end
        rdata = hrdata;
        @(posedge mem_intf);
    endtask

    task automatic retire_phase(input phase_t ph, input int unsigned lows,
                                input logic [31:0] rdata);
        int unsigned idx;
        logic [31:0] exp;
        idx = word_index(ph.addr);
        exp = '0;
        compare_word("hready wait cycles", ph.exp_wait, lows);
        if (is_access(ph) && !ph.write && ref_mem.exists(idx)) begin
            exp = ref_mem[idx];                    // Unwritten words read as zero.
        end
        compare_word("hrdata", exp, rdata);
        if (is_access(ph) && ph.write) begin
            ref_mem[idx] = ph.data;
        end
    endtask

    // One bus edge: accept the address phase, retire the data phase.
    task automatic advance_bus(input phase_t next_ph);
        int unsigned lows;
        logic [31:0] rdata;
        await_ready(lows, rdata);
        retire_phase(data_ph, lows, rdata);
        haddr  <= next_ph.addr;
        hwrite <= next_ph.write;
        htrans <= next_ph.trans;
        hburst <= next_ph.burst;
        hwdata <= (is_access(addr_ph) && addr_ph.write) ? addr_ph.data : '0;
        data_ph = addr_ph;
        addr_ph = next_ph;
    endtask

    task automatic run_entry(input entry_t e);
        phase_t ph;
        int     beats;
        beats = (e.burst == SINGLE) ? 1 : 4;
        for (int b = 0; b < beats; b++) begin
            ph.burst = e.burst;
            ph.write = e.write;
            ph.addr  = beat_addr(e.burst, e.addr, b);
            ph.data  = e.data[b];
            if (e.busy && b == 2) begin
                ph.trans    = BUSY;                // Holds the address of the coming beat.
                ph.exp_wait = 0;
                advance_bus(ph);
            end
            ph.trans    = (b == 0) ? NONSEQ : SEQ;
            ph.exp_wait = e.exp_wait;
            advance_bus(ph);
        end
    endtask

    task automatic add_entry(input hburst_e burst, input logic write, input logic [31:0] addr,
                             input logic busy, input int unsigned exp_wait);
        entry_t e;
        e.burst    = burst;
        e.write    = write;
        e.addr     = addr;
        e.busy     = busy;
        e.exp_wait = exp_wait;
        for (int b = 0; b < 4; b++) begin
            e.data[b] = $random(seed);
        end
        xfer_table.push_back(e);
    endtask

    // Burst, write, start address, BUSY insert, expected wait cycles.
    task automatic fill_table();
        add_entry(SINGLE, 1'b0, 32'h0000_0100, 1'b0, READ_WAIT);   // Cleared array.
        add_entry(SINGLE, 1'b1, 32'h0000_0010, 1'b0, WRITE_WAIT);
        add_entry(SINGLE, 1'b1, 32'h0000_0014, 1'b0, WRITE_WAIT);
        add_entry(SINGLE, 1'b0, 32'h0000_0010, 1'b0, READ_WAIT);
        add_entry(SINGLE, 1'b0, 32'h0000_0014, 1'b0, READ_WAIT);
        add_entry(SINGLE, 1'b0, 32'h0000_1010, 1'b0, READ_WAIT);   // Aliases word 4.
        add_entry(INCR4,  1'b1, 32'h0000_0200, 1'b0, WRITE_WAIT);
        add_entry(INCR4,  1'b0, 32'h0000_0200, 1'b0, READ_WAIT);
        add_entry(SINGLE, 1'b0, 32'h0000_020C, 1'b0, READ_WAIT);
        add_entry(WRAP4,  1'b1, 32'h0000_0308, 1'b0, WRITE_WAIT);  // Words 2, 3, 0, 1.
        add_entry(SINGLE, 1'b0, 32'h0000_0300, 1'b0, READ_WAIT);
        add_entry(SINGLE, 1'b0, 32'h0000_0304, 1'b0, READ_WAIT);
        add_entry(SINGLE, 1'b0, 32'h0000_0308, 1'b0, READ_WAIT);
        add_entry(SINGLE, 1'b0, 32'h0000_030C, 1'b0, READ_WAIT);
        add_entry(WRAP4,  1'b0, 32'h0000_0308, 1'b0, READ_WAIT);
        add_entry(INCR4,  1'b1, 32'h0000_0400, 1'b1, WRITE_WAIT);
        add_entry(INCR4,  1'b0, 32'h0000_0400, 1'b1, READ_WAIT);
        add_entry(WRAP4,  1'b1, 32'h0000_050C, 1'b1, WRITE_WAIT);
        add_entry(WRAP4,  1'b0, 32'h0000_050C, 1'b1, READ_WAIT);
        add_entry(INCR,   1'b1, 32'h0000_0600, 1'b0, WRITE_WAIT);
        add_entry(INCR,   1'b0, 32'h0000_0600, 1'b1, READ_WAIT);
        add_entry(SINGLE, 1'b0, 32'h0000_0408, 1'b0, READ_WAIT);
    endtask

    initial begin
        seed    = 84157;
        rst_n   <= 1'b0;
        haddr   <= '0;
        hwrite  <= 1'b0;
        htrans  <= IDLE;
        hburst  <= SINGLE;
        hwdata  <= '0;
        idle_ph = '0;                              // IDLE, SINGLE, no data.
        addr_ph = idle_ph;
        data_ph = idle_ph;
        fill_table();
        repeat (4) @(posedge mem_intf);
        rst_n <= 1'b1;
        @(negedge mem_intf);
        compare_word("hready", 32'd1, {31'd0, hready});
        compare_word("hrdata", '0, hrdata);
        foreach (xfer_table[i]) begin
            run_entry(xfer_table[i]);
        end
        advance_bus(idle_ph);                      // Drain the pipeline.
        advance_bus(idle_ph);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
source/ahb_mem_pkg.sv
source/ahb_transfer_handler.sv
source/mem_wait_ctrl.sv
source/mem_word_array.sv
source/ahb_mem_top.sv
testbench/ahb_mem_assert.sv
testbench/ahb_mem_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = ahb_mem_tb
FILELIST  = list.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "STATUS: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
